/* include/link_test_macros.svh */
`ifndef LINK_TEST_MACROS_SVH
`define LINK_TEST_MACROS_SVH

////////////////////////////////////////
// 8b/10b special and data codes
////////////////////////////////////////

// sync idle pair is D5.6 over K28.5
`define LT_K28_5 8'hBC
`define LT_D5_6 8'hC5

// start of frame is K28.2 over K27.7
`define LT_K27_7 8'hFB
`define LT_K28_2 8'h5C

// end of frame is K29.7 over K30.7
`define LT_K30_7 8'hFE
`define LT_K29_7 8'hFD

////////////////////////////////////////
// frame fields and sizes
////////////////////////////////////////

`define LT_HEAD_0 16'hEB90
`define LT_HEAD_1 16'hE116
`define LT_FILE_END 16'h8101

// idles sent ahead of every frame
`define LT_SYNC_WORDS 4

`define LT_FIFO_DEPTH 16

`endif

/* hw/link_test_pkg.sv */
package link_test_pkg;

    // generator walks one field per accepted word
    typedef enum logic [3:0] {
        GEN_IDLE      = 4'd0,
        GEN_SYNC      = 4'd1,
        GEN_SOF       = 4'd2,
        GEN_HEAD0     = 4'd3,
        GEN_HEAD1     = 4'd4,
        GEN_FILE_END  = 4'd5,
        GEN_FRAME_CNT = 4'd6,
        GEN_LENGTH    = 4'd7,
        GEN_DATA      = 4'd8,
        GEN_CHECKSUM  = 4'd9,
        GEN_EOF       = 4'd10
    } gen_state_t;

    // checker state names the field expected next
    typedef enum logic [3:0] {
        CHK_HUNT      = 4'd0,
        CHK_SYNC      = 4'd1,
        CHK_SOF       = 4'd2,
        CHK_HEAD0     = 4'd3,
        CHK_HEAD1     = 4'd4,
        CHK_FILE_END  = 4'd5,
        CHK_FRAME_CNT = 4'd6,
        CHK_LENGTH    = 4'd7,
        CHK_DATA      = 4'd8,
        CHK_CHECKSUM  = 4'd9,
        CHK_EOF       = 4'd10
    } chk_state_t;

    // code 7 stays free as the length field is not checked
    typedef enum logic [3:0] {
        ERR_NONE      = 4'd0,
        ERR_SYNC      = 4'd1,
        ERR_SOF       = 4'd2,
        ERR_HEAD0     = 4'd3,
        ERR_HEAD1     = 4'd4,
        ERR_FILE_END  = 4'd5,
        ERR_FRAME_CNT = 4'd6,
        ERR_DATA      = 4'd8,
        ERR_CHECKSUM  = 4'd9,
        ERR_EOF       = 4'd10
    } err_code_t;

endpackage

/* hw/frame_generator.sv */
`timescale 1ns/1ps
`include "link_test_macros.svh"

module frame_generator (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_soft_rst,
    input  logic        i_gen_ena,
    input  logic        i_inject_error,
    input  logic [15:0] i_frame_words,
    input  logic        i_full,
    output logic        o_wr,
    output logic [15:0] o_data,
    output logic        o_k_msb,
    output logic        o_k_lsb
);

    import link_test_pkg::*;

    gen_state_t  state;
    logic [15:0] word_cnt;
    logic [15:0] frame_cnt;
    logic [15:0] frame_words;
    logic [15:0] frame_len;
    logic [15:0] checksum;
    logic        inj_pend;
    logic        step;

    // one word per cycle unless stalled by the lane
    assign step      = i_gen_ena & ~i_full;
    assign o_wr      = step & (state != GEN_IDLE);
    assign frame_len = {frame_words[14:0], 1'b0};

    ////////////////////////////////////////
    // word for the current field
    ////////////////////////////////////////

    always_comb begin
        o_data  = 16'h0000;
        o_k_msb = 1'b0;
        o_k_lsb = 1'b0;
        case (state)
            GEN_SYNC: begin
                o_data  = {`LT_D5_6, `LT_K28_5};
                o_k_lsb = 1'b1;
            end
            GEN_SOF: begin
                o_data  = {`LT_K28_2, `LT_K27_7};
                o_k_msb = 1'b1;
                o_k_lsb = 1'b1;
            end
            GEN_HEAD0:     o_data = `LT_HEAD_0;
            GEN_HEAD1:     o_data = `LT_HEAD_1;
            GEN_FILE_END:  o_data = `LT_FILE_END;
            GEN_FRAME_CNT: o_data = frame_cnt;
            GEN_LENGTH:    o_data = frame_len;
            // injected fault flips the lsb of the ramp only
            GEN_DATA:      o_data = word_cnt ^ {15'd0, inj_pend};
            GEN_CHECKSUM:  o_data = checksum;
            GEN_EOF: begin
                o_data  = {`LT_K29_7, `LT_K30_7};
                o_k_msb = 1'b1;
                o_k_lsb = 1'b1;
            end
            default: o_data = 16'h0000;
        endcase
    end

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= GEN_IDLE;
            word_cnt  <= 16'd0;
            frame_cnt <= 16'd0;
        end else if (i_soft_rst) begin
            state     <= GEN_IDLE;
            word_cnt  <= 16'd0;
            frame_cnt <= 16'd0;
        end else if (step) begin
            case (state)
                GEN_IDLE: begin
                    word_cnt <= 16'd0;
                    state    <= GEN_SYNC;
                end
                GEN_SYNC: begin
                    if (word_cnt == 16'(`LT_SYNC_WORDS - 1)) begin
                        word_cnt <= 16'd0;
                        state    <= GEN_SOF;
                    end else begin
                        word_cnt <= word_cnt + 16'd1;
                    end
                end
                GEN_SOF:       state <= GEN_HEAD0;
                GEN_HEAD0:     state <= GEN_HEAD1;
                GEN_HEAD1:     state <= GEN_FILE_END;
                GEN_FILE_END:  state <= GEN_FRAME_CNT;
                GEN_FRAME_CNT: state <= GEN_LENGTH;
                GEN_LENGTH: begin
                    word_cnt <= 16'd0;
                    state    <= GEN_DATA;
                end
                GEN_DATA: begin
                    word_cnt <= word_cnt + 16'd1;
                    if (word_cnt == frame_words - 16'd1) begin
                        state <= GEN_CHECKSUM;
                    end
                end
                GEN_CHECKSUM:  state <= GEN_EOF;
                GEN_EOF: begin
                    frame_cnt <= frame_cnt + 16'd1;
                    word_cnt  <= 16'd0;
                    state     <= GEN_SYNC;
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    // size sampled at frame start and sum kept from HEAD_1 through the ramp
    always_ff @(posedge clk) begin
        if (step) begin
            case (state)
                GEN_SOF:       frame_words <= (i_frame_words == 16'd0) ? 16'd1 : i_frame_words;
                GEN_HEAD1:     checksum <= `LT_HEAD_1;
                GEN_FILE_END:  checksum <= checksum + `LT_FILE_END;
                GEN_FRAME_CNT: checksum <= checksum + frame_cnt;
                GEN_LENGTH:    checksum <= checksum + frame_len;
                GEN_DATA:      checksum <= checksum + word_cnt;
                default:       checksum <= checksum;
            endcase
        end
    end

    // inject request waits for the next data word
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            inj_pend <= 1'b0;
        end else if (i_soft_rst) begin
            inj_pend <= 1'b0;
        end else if (i_inject_error) begin
            inj_pend <= 1'b1;
        end else if (step && state == GEN_DATA) begin
            inj_pend <= 1'b0;
        end
    end

    a_ramp_in_range: assert property (@(posedge clk) disable iff (!i_arst_n)
        state == GEN_DATA |-> word_cnt < frame_words)
        else $error("ramp index ran past the frame size");

endmodule

/* hw/lane_fifo.sv */
`timescale 1ns/1ps

module lane_fifo #(
    parameter int DEPTH = 16
) (
    input  logic        clk,
    input  logic        i_arst_n,
    input  logic        i_soft_rst,
    input  logic        i_wr,
    input  logic [15:0] i_data,
    input  logic        i_k_msb,
    input  logic        i_k_lsb,
    input  logic        i_rd_ena,
    output logic        o_rd,
    output logic [15:0] o_data,
    output logic        o_k_msb,
    output logic        o_k_lsb,
    output logic        o_full
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    // each entry is {k_msb, k_lsb, data}
    logic [17:0]   mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign o_full = (count == CW'(DEPTH));
    assign push   = i_wr & ~o_full;
    assign pop    = i_rd_ena & (count != '0);

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            o_rd   <= 1'b0;
        end else if (i_soft_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            o_rd   <= 1'b0;
        end else begin
            o_rd <= pop;
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and output word
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {i_k_msb, i_k_lsb, i_data};
        end
        if (pop) begin
            {o_k_msb, o_k_lsb, o_data} <= mem[rd_ptr];
        end
    end

    // producer must honour the full level
    a_no_write_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_wr |-> !o_full)
        else $error("lane word dropped, write while full");

endmodule

/* hw/rx_frame_checker.sv */
`timescale 1ns/1ps
`include "link_test_macros.svh"

module rx_frame_checker (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_soft_rst,
    input  logic                     i_valid,
    input  logic [15:0]              i_data,
    input  logic                     i_k_msb,
    input  logic                     i_k_lsb,
    output logic                     o_check_error,
    output link_test_pkg::err_code_t o_error_code,
    output logic                     o_frame_ok,
    output logic [15:0]              o_error_count
);

    import link_test_pkg::*;

    chk_state_t  state;
    chk_state_t  next_state;
    err_code_t   fail;
    logic        done;

    logic        rx_valid;
    logic [15:0] rx_data;
    logic        rx_k_msb;
    logic        rx_k_lsb;

    logic [15:0] last_cnt;
    logic [15:0] cnt;
    logic [15:0] data_len;
    logic [15:0] sum;

    logic        is_sync;
    logic        is_sof;
    logic        is_eof;
    logic        is_plain;

    // input stage
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_valid <= 1'b0;
        end else if (i_soft_rst) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        rx_data  <= i_data;
        rx_k_msb <= i_k_msb;
        rx_k_lsb <= i_k_lsb;
    end

    assign is_sync  = ~rx_k_msb & rx_k_lsb & (rx_data == {`LT_D5_6, `LT_K28_5});
    assign is_sof   = rx_k_msb & rx_k_lsb & (rx_data == {`LT_K28_2, `LT_K27_7});
    assign is_eof   = rx_k_msb & rx_k_lsb & (rx_data == {`LT_K29_7, `LT_K30_7});
    assign is_plain = ~rx_k_msb & ~rx_k_lsb;

    ////////////////////////////////////////
    // field compare and next state
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        fail       = ERR_NONE;
        done       = 1'b0;
        if (rx_valid) begin
            case (state)
                // stray words while hunting are dropped quietly
                CHK_HUNT: begin
                    if (is_sync) begin
                        next_state = CHK_SYNC;
                    end else if (is_sof) begin
                        fail = ERR_SYNC;
                    end
                end
                CHK_SYNC: begin
                    if (!is_sync) begin
                        fail = ERR_SYNC;
                    end else if (cnt == 16'(`LT_SYNC_WORDS - 1)) begin
                        next_state = CHK_SOF;
                    end
                end
                CHK_SOF: begin
                    if (is_sof) begin
                        next_state = CHK_HEAD0;
                    end else begin
                        fail = ERR_SOF;
                    end
                end
                CHK_HEAD0: begin
                    next_state = CHK_HEAD1;
                    if (!is_plain || rx_data != `LT_HEAD_0) begin
                        fail = ERR_HEAD0;
                    end
                end
                CHK_HEAD1: begin
                    next_state = CHK_FILE_END;
                    if (!is_plain || rx_data != `LT_HEAD_1) begin
                        fail = ERR_HEAD1;
                    end
                end
                CHK_FILE_END: begin
                    next_state = CHK_FRAME_CNT;
                    if (!is_plain || rx_data != `LT_FILE_END) begin
                        fail = ERR_FILE_END;
                    end
                end
                CHK_FRAME_CNT: begin
                    next_state = CHK_LENGTH;
                    if (!is_plain || rx_data != last_cnt + 16'd1) begin
                        fail = ERR_FRAME_CNT;
                    end
                end
                // an empty ramp goes straight to the checksum
                CHK_LENGTH: begin
                    next_state = (rx_data[15:1] == 15'd0) ? CHK_CHECKSUM : CHK_DATA;
                end
                CHK_DATA: begin
                    if (!is_plain || rx_data != cnt) begin
                        fail = ERR_DATA;
                    end else if (cnt == data_len - 16'd1) begin
                        next_state = CHK_CHECKSUM;
                    end
                end
                CHK_CHECKSUM: begin
                    next_state = CHK_EOF;
                    if (!is_plain || rx_data != sum) begin
                        fail = ERR_CHECKSUM;
                    end
                end
                CHK_EOF: begin
                    next_state = CHK_HUNT;
                    if (is_eof) begin
                        done = 1'b1;
                    end else begin
                        fail = ERR_EOF;
                    end
                end
                default: next_state = CHK_HUNT;
            endcase
            if (fail != ERR_NONE) begin
                next_state = CHK_HUNT;
            end
        end
    end

    ////////////////////////////////////////
    // state, reporting and error count
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state         <= CHK_HUNT;
            last_cnt      <= 16'hFFFF;
            o_check_error <= 1'b0;
            o_error_code  <= ERR_NONE;
            o_frame_ok    <= 1'b0;
            o_error_count <= 16'd0;
        end else if (i_soft_rst) begin
            state         <= CHK_HUNT;
            last_cnt      <= 16'hFFFF;
            o_check_error <= 1'b0;
            o_error_code  <= ERR_NONE;
            o_frame_ok    <= 1'b0;
            o_error_count <= 16'd0;
        end else begin
            state         <= next_state;
            o_check_error <= (fail != ERR_NONE);
            o_error_code  <= fail;
            o_frame_ok    <= done;
            // count even a bad value so the next frame lines up again
            if (rx_valid && state == CHK_FRAME_CNT) begin
                last_cnt <= rx_data;
            end
            if (fail != ERR_NONE && o_error_count != 16'hFFFF) begin
                o_error_count <= o_error_count + 16'd1;
            end
        end
    end

    // field counters and running sum restart on entry
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                CHK_HUNT:      cnt <= 16'd1;
                CHK_SYNC:      cnt <= cnt + 16'd1;
                CHK_HEAD1:     sum <= rx_data;
                CHK_FILE_END:  sum <= sum + rx_data;
                CHK_FRAME_CNT: sum <= sum + rx_data;
                CHK_LENGTH: begin
                    sum      <= sum + rx_data;
                    data_len <= {1'b0, rx_data[15:1]};
                    cnt      <= 16'd0;
                end
                CHK_DATA: begin
                    sum <= sum + rx_data;
                    cnt <= cnt + 16'd1;
                end
                default:       cnt <= cnt;
            endcase
        end
    end

    a_data_in_range: assert property (@(posedge clk) disable iff (!i_arst_n)
        state == CHK_DATA |-> cnt < data_len)
        else $error("data index ran past the received length");

endmodule

/* hw/link_test_top.sv */
`timescale 1ns/1ps
`include "link_test_macros.svh"

module link_test_top (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  logic                     i_soft_rst,
    input  logic                     i_gen_ena,
    input  logic                     i_check_ena,
    input  logic                     i_inject_error,
    input  logic [15:0]              i_frame_words,
    output logic                     o_check_error,
    output link_test_pkg::err_code_t o_error_code,
    output logic                     o_frame_ok,
    output logic [15:0]              o_error_count
);

    // generator side of the lane
    logic        gen_wr;
    logic [15:0] gen_data;
    logic        gen_k_msb;
    logic        gen_k_lsb;
    logic        fifo_full;

    // checker side of the lane
    logic        fifo_rd;
    logic [15:0] fifo_data;
    logic        fifo_k_msb;
    logic        fifo_k_lsb;

    frame_generator u_gen (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_soft_rst     (i_soft_rst),
        .i_gen_ena      (i_gen_ena),
        .i_inject_error (i_inject_error),
        .i_frame_words  (i_frame_words),
        .i_full         (fifo_full),
        .o_wr           (gen_wr),
        .o_data         (gen_data),
        .o_k_msb        (gen_k_msb),
        .o_k_lsb        (gen_k_lsb)
    );

    lane_fifo #(
        .DEPTH (`LT_FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_soft_rst (i_soft_rst),
        .i_wr       (gen_wr),
        .i_data     (gen_data),
        .i_k_msb    (gen_k_msb),
        .i_k_lsb    (gen_k_lsb),
        .i_rd_ena   (i_check_ena),
        .o_rd       (fifo_rd),
        .o_data     (fifo_data),
        .o_k_msb    (fifo_k_msb),
        .o_k_lsb    (fifo_k_lsb),
        .o_full     (fifo_full)
    );

    rx_frame_checker u_chk (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_soft_rst    (i_soft_rst),
        .i_valid       (fifo_rd),
        .i_data        (fifo_data),
        .i_k_msb       (fifo_k_msb),
        .i_k_lsb       (fifo_k_lsb),
        .o_check_error (o_check_error),
        .o_error_code  (o_error_code),
        .o_frame_ok    (o_frame_ok),
        .o_error_count (o_error_count)
    );

endmodule

/* tests/link_test_tb.sv */
`timescale 1ns/1ps
`include "link_test_macros.svh"

module link_test_tb;

    import link_test_pkg::*;

    // longest frame is sync, eight fixed fields and a 16 word ramp
    localparam int MAX_FRAME_CYCLES = `LT_SYNC_WORDS + 8 + 16;
    localparam int FRAMES_TOTAL     = 33;
    localparam int STALL_CYCLES     = 100;
    // factor 4 covers lane latency and the frame cut short by the fault
    localparam int TIMEOUT_CYCLES   = FRAMES_TOTAL * MAX_FRAME_CYCLES * 4 + STALL_CYCLES + 200;

    logic        clk          = 1'b0;
    logic        arst_n       = 1'b0;
    logic        soft_rst     = 1'b0;
    logic        gen_ena      = 1'b0;
    logic        check_ena    = 1'b0;
    logic        inject_error = 1'b0;
    logic [15:0] frame_words  = 16'd8;
    logic        check_error;
    err_code_t   error_code;
    logic        frame_ok;
    logic [15:0] error_count;

    logic [31:0] lfsr = 32'h54dafc82;
    int          cycle_count     = 0;
    int          frames_ok       = 0;
    int          errors_seen     = 0;
    int          errors_expected = 0;
    int          count_expected  = 0;
    logic        stall_quiet     = 1'b0;
    int          fail_count      = 0;
    int          fails_at_start  = 0;
    int          tests_passed    = 0;
    int          tests_failed    = 0;

    link_test_top dut_i (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .i_soft_rst     (soft_rst),
        .i_gen_ena      (gen_ena),
        .i_check_ena    (check_ena),
        .i_inject_error (inject_error),
        .i_frame_words  (frame_words),
        .o_check_error  (check_error),
        .o_error_code   (error_code),
        .o_frame_ok     (frame_ok),
        .o_error_count  (error_count)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // four bits with one step each give 1 to 16 words
    task automatic draw_length(output logic [15:0] len);
        logic [3:0] bits;
        bits = 4'd0;
        for (int i = 0; i < 4; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[2:0], lfsr[0]};
        end
        len = 16'(bits) + 16'd1;
    endtask

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        fail_count++;
    endtask

    task automatic begin_test();
        fails_at_start = fail_count;
    endtask

    task automatic end_test(input string name);
        if (fail_count == fails_at_start) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_ok + n;
        while (frames_ok < target) begin
            @(posedge clk);
        end
    endtask

    ////////////////////////////////////////
    // model counters and length stimulus
    ////////////////////////////////////////

    always @(posedge clk) begin
        logic [15:0] len;
        cycle_count <= cycle_count + 1;
        if (frame_ok) begin
            frames_ok <= frames_ok + 1;
        end
        if (check_error) begin
            errors_seen <= errors_seen + 1;
        end
        // new random size after every good frame
        if (!arst_n || frame_ok) begin
            draw_length(len);
            frame_words <= len;
        end
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    a_error_expected: assert property (@(posedge clk) disable iff (!arst_n)
        check_error |-> (errors_seen < errors_expected && error_code == ERR_DATA))
        else report_error("check error that no injected fault explains");

    a_code_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !check_error |-> error_code == ERR_NONE)
        else report_error("error code set without an error pulse");

    a_ok_alone: assert property (@(posedge clk) disable iff (!arst_n)
        !(frame_ok && check_error))
        else report_error("frame ok and check error together");

    a_quiet_stall: assert property (@(posedge clk) disable iff (!arst_n)
        stall_quiet |-> !frame_ok)
        else report_error("frame ok while checking was disabled");

    a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
        error_count <= 16'(count_expected))
        else report_error("error count above the number of injected faults");

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        begin_test();
        @(posedge clk);
        assert (!check_error && !frame_ok && error_code == ERR_NONE && error_count == 16'd0)
            else report_error("outputs not idle after reset");
        end_test("reset");

        begin_test();
        gen_ena   <= 1'b1;
        check_ena <= 1'b1;
        wait_frames(20);
        assert (error_count == 16'(count_expected))
            else report_error("error count not zero after clean frames");
        end_test("clean_frames");

        // one corrupted ramp word
        begin_test();
        wait_frames(1);
        repeat (10) @(posedge clk);
        inject_error <= 1'b1;
        errors_expected++;
        count_expected++;
        @(posedge clk);
        inject_error <= 1'b0;
        while (errors_seen < errors_expected) begin
            @(posedge clk);
        end
        wait_frames(2);
        assert (error_count == 16'(count_expected))
            else report_error("error count did not rise by one");
        end_test("inject_error");

        // lane fills and stalls the generator
        begin_test();
        check_ena <= 1'b0;
        repeat (4) @(posedge clk);
        stall_quiet <= 1'b1;
        repeat (STALL_CYCLES - 4) @(posedge clk);
        stall_quiet <= 1'b0;
        check_ena   <= 1'b1;
        wait_frames(5);
        assert (error_count == 16'(count_expected))
            else report_error("error count changed across the stall");
        end_test("back_pressure");

        begin_test();
        soft_rst <= 1'b1;
        @(posedge clk);
        soft_rst <= 1'b0;
        count_expected = 0;
        @(posedge clk);
        assert (error_count == 16'd0)
            else report_error("error count not cleared by soft reset");
        wait_frames(5);
        assert (error_count == 16'(count_expected))
            else report_error("errors after soft reset");
        end_test("soft_reset");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* link_test_top.f */
+incdir+include
hw/link_test_pkg.sv
hw/frame_generator.sv
hw/lane_fifo.sv
hw/rx_frame_checker.sv
hw/link_test_top.sv
tests/link_test_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the link test with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module link_test_tb -f link_test_top.f -o link_test_sim

out=$(./obj_dir/link_test_sim)
echo "$out"

if echo "$out" | grep -q '^=== PASS ===$'; then
    exit 0
else
    exit 1
fi
